/* hw/rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // base opcodes, bits [6:0]
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_COPY2,  // lui
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU
    } alu_op_e;

    typedef enum logic {
        OP1_RS1,
        OP1_PC
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LINK,    // pc + 4
        WB_LOAD
    } wb_sel_e;

endpackage

/* hw/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::word_t     inst_i,
    output rv_pkg::reg_addr_t rs1_addr_o,
    output rv_pkg::reg_addr_t rs2_addr_o,
    output rv_pkg::reg_addr_t rd_addr_o,
    output rv_pkg::word_t     imm_o,
    output rv_pkg::alu_op_e   alu_op_o,
    output rv_pkg::op1_sel_e  op1_sel_o,
    output rv_pkg::op2_sel_e  op2_sel_o,
    output rv_pkg::wb_sel_e   wb_sel_o,
    output logic              rf_wen_o,
    output logic              is_load_o,
    output logic              is_store_o,
    output logic              is_branch_o,
    output logic              is_jump_o,
    output logic              is_jalr_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       wen;

    // shared by OP and OP-IMM, alt picks sub/sra
    function automatic rv_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];
    assign rf_wen_o   = wen && (inst_i[11:7] != 5'd0); // x0 never written

    always_comb begin
        // defaults decode as a no-op
        wen         = 1'b0;
        imm_o       = {{20{inst_i[31]}}, inst_i[31:20]}; // I-type
        alu_op_o    = rv_pkg::ALU_ADD;
        op1_sel_o   = rv_pkg::OP1_RS1;
        op2_sel_o   = rv_pkg::OP2_IMM;
        wb_sel_o    = rv_pkg::WB_ALU;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        is_jump_o   = 1'b0;
        is_jalr_o   = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                op2_sel_o = rv_pkg::OP2_RS2;
                alu_op_o  = alu_from_funct(funct3, funct7[5]);
                wen       = (funct7 == 7'h00) ||
                            (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rv_pkg::OPC_OP_IMM: begin
                alu_op_o = alu_from_funct(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001)
                    wen = (funct7 == 7'h00);
                else if (funct3 == 3'b101)
                    wen = (funct7 == 7'h00) || (funct7 == 7'h20);
                else
                    wen = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                wb_sel_o  = rv_pkg::WB_LOAD;
                is_load_o = (funct3 == 3'b010); // lw only
                wen       = is_load_o;
            end
            rv_pkg::OPC_STORE: begin
                imm_o      = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
                is_store_o = (funct3 == 3'b010);
            end
            rv_pkg::OPC_BRANCH: begin
                imm_o       = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                               inst_i[11:8], 1'b0};
                op2_sel_o   = rv_pkg::OP2_RS2;
                is_branch_o = (funct3 != 3'b010) && (funct3 != 3'b011);
                case (funct3)
                    3'b000:  alu_op_o = rv_pkg::ALU_BEQ;
                    3'b001:  alu_op_o = rv_pkg::ALU_BNE;
                    3'b100:  alu_op_o = rv_pkg::ALU_BLT;
                    3'b101:  alu_op_o = rv_pkg::ALU_BGE;
                    3'b110:  alu_op_o = rv_pkg::ALU_BLTU;
                    default: alu_op_o = rv_pkg::ALU_BGEU;
                endcase
            end
            rv_pkg::OPC_JAL: begin
                imm_o     = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                             inst_i[30:21], 1'b0};
                op1_sel_o = rv_pkg::OP1_PC;
                wb_sel_o  = rv_pkg::WB_LINK;
                is_jump_o = 1'b1;
                wen       = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                wb_sel_o  = rv_pkg::WB_LINK;
                is_jump_o = (funct3 == 3'b000);
                is_jalr_o = is_jump_o;
                wen       = is_jump_o;
            end
            rv_pkg::OPC_LUI: begin
                imm_o    = {inst_i[31:12], 12'b0};
                alu_op_o = rv_pkg::ALU_COPY2;
                wen      = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                imm_o     = {inst_i[31:12], 12'b0};
                op1_sel_o = rv_pkg::OP1_PC;
                wen       = 1'b1;
            end
            default: ; // unknown opcode, nop
        endcase
    end

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
    input  rv_pkg::word_t    pc_i,
    input  rv_pkg::word_t    rs1_data_i,
    input  rv_pkg::word_t    rs2_data_i,
    input  rv_pkg::word_t    imm_i,
    input  rv_pkg::alu_op_e  alu_op_i,
    input  rv_pkg::op1_sel_e op1_sel_i,
    input  rv_pkg::op2_sel_e op2_sel_i,
    input  logic             is_branch_i,
    input  logic             is_jump_i,
    input  logic             is_jalr_i,
    output rv_pkg::word_t    alu_result_o,
    output rv_pkg::word_t    link_o,
    output rv_pkg::word_t    next_pc_o
);

    rv_pkg::word_t op1;
    rv_pkg::word_t op2;
    rv_pkg::word_t pc_plus4;
    logic          cmp;

    assign op1      = (op1_sel_i == rv_pkg::OP1_PC) ? pc_i : rs1_data_i;
    assign op2      = (op2_sel_i == rv_pkg::OP2_IMM) ? imm_i : rs2_data_i;
    assign pc_plus4 = pc_i + 32'd4;
    assign link_o   = pc_plus4;

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_BEQ:  cmp = (op1 == op2);
            rv_pkg::ALU_BNE:  cmp = (op1 != op2);
            rv_pkg::ALU_BLT:  cmp = ($signed(op1) < $signed(op2));
            rv_pkg::ALU_BGE:  cmp = ($signed(op1) >= $signed(op2));
            rv_pkg::ALU_BLTU: cmp = (op1 < op2);
            rv_pkg::ALU_BGEU: cmp = (op1 >= op2);
            default:          cmp = 1'b0;
        endcase
    end

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_ADD:   alu_result_o = op1 + op2;
            rv_pkg::ALU_SUB:   alu_result_o = op1 - op2;
            rv_pkg::ALU_AND:   alu_result_o = op1 & op2;
            rv_pkg::ALU_OR:    alu_result_o = op1 | op2;
            rv_pkg::ALU_XOR:   alu_result_o = op1 ^ op2;
            rv_pkg::ALU_SLL:   alu_result_o = op1 << op2[4:0];
            rv_pkg::ALU_SRL:   alu_result_o = op1 >> op2[4:0];
            rv_pkg::ALU_SRA:   alu_result_o = $signed(op1) >>> op2[4:0];
            rv_pkg::ALU_SLT:   alu_result_o = {31'b0, $signed(op1) < $signed(op2)};
            rv_pkg::ALU_SLTU:  alu_result_o = {31'b0, op1 < op2};
            rv_pkg::ALU_COPY2: alu_result_o = op2;
            default:           alu_result_o = {31'b0, cmp}; // branch compares
        endcase
    end

    always_comb begin
        if (is_jalr_i)
            next_pc_o = {alu_result_o[31:1], 1'b0};
        else if (is_jump_i || (is_branch_i && cmp))
            next_pc_o = pc_i + imm_i;
        else
            next_pc_o = pc_plus4;
    end

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_addr_i,
    input  rv_pkg::reg_addr_t rs2_addr_i,
    input  rv_pkg::reg_addr_t rd_addr_i,
    input  logic              commit_i,
    input  logic              rf_wen_i,
    input  rv_pkg::wb_sel_e   wb_sel_i,
    input  rv_pkg::word_t     alu_result_i,
    input  rv_pkg::word_t     link_i,
    input  rv_pkg::word_t     load_data_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o
);

    rv_pkg::word_t regs [32];
    rv_pkg::word_t wb_data;

    always_comb begin
        case (wb_sel_i)
            rv_pkg::WB_LINK: wb_data = link_i;
            rv_pkg::WB_LOAD: wb_data = load_data_i;
            default:         wb_data = alu_result_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (commit_i && rf_wen_i) begin
            regs[rd_addr_i] <= wb_data;
        end
    end

    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

/* hw/rv_control.sv */
`timescale 1ns/1ps

module rv_control #(
    parameter rv_pkg::word_t RESET_PC = '0,
    parameter rv_pkg::word_t HALT_PC  = 32'h44
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          is_load_i,
    input  logic          is_store_i,
    input  rv_pkg::word_t next_pc_i,
    input  logic          dmem_ready_i,
    input  logic          dmem_rvalid_i,
    output rv_pkg::word_t pc_o,
    output logic          dmem_valid_o,
    output logic          commit_o,
    output logic          halt_o
);

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_LOAD_WAIT,
        ST_HALT
    } ctrl_state_e;

    ctrl_state_e   state_q;
    ctrl_state_e   state_d;
    rv_pkg::word_t pc_q;
    logic          mem_op;

    assign mem_op       = is_load_i || is_store_i;
    assign dmem_valid_o = (state_q == ST_EXEC) && mem_op; // held until ready
    assign halt_o       = (pc_q == HALT_PC);
    assign pc_o         = pc_q;

    always_comb begin
        state_d  = state_q;
        commit_o = 1'b0;
        case (state_q)
            ST_FETCH: state_d = halt_o ? ST_HALT : ST_EXEC;
            ST_EXEC: begin
                if (!mem_op || (is_store_i && dmem_ready_i)) begin
                    commit_o = 1'b1;
                    state_d  = ST_FETCH;
                end else if (dmem_ready_i) begin
                    state_d = ST_LOAD_WAIT; // read accepted, data comes later
                end
            end
            ST_LOAD_WAIT: begin
                if (dmem_rvalid_i) begin
                    commit_o = 1'b1;
                    state_d  = ST_FETCH;
                end
            end
            ST_HALT: state_d = ST_HALT; // parked until reset
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_FETCH;
            pc_q    <= RESET_PC;
        end else begin
            state_q <= state_d;
            if (commit_o)
                pc_q <= next_pc_i;
        end
    end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = '0,
    parameter rv_pkg::word_t HALT_PC  = 32'h44
) (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t imem_addr_o,
    input  rv_pkg::word_t imem_data_i,
    output logic          dmem_valid_o,
    input  logic          dmem_ready_i,
    output logic          dmem_we_o,
    output rv_pkg::word_t dmem_addr_o,
    output rv_pkg::word_t dmem_wdata_o,
    input  rv_pkg::word_t dmem_rdata_i,
    input  logic          dmem_rvalid_i,
    output logic          halt_o
);

    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::reg_addr_t rd_addr;
    rv_pkg::word_t     imm;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::op1_sel_e  op1_sel;
    rv_pkg::op2_sel_e  op2_sel;
    rv_pkg::wb_sel_e   wb_sel;
    logic              rf_wen;
    logic              is_load;
    logic              is_store;
    logic              is_branch;
    logic              is_jump;
    logic              is_jalr;
    rv_pkg::word_t     pc;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     alu_result;
    rv_pkg::word_t     link;
    rv_pkg::word_t     next_pc;
    logic              commit;

    assign imem_addr_o  = pc;
    assign dmem_addr_o  = alu_result; // rs1 + imm for lw/sw
    assign dmem_wdata_o = rs2_data;
    assign dmem_we_o    = is_store;

    rv_decoder u_decoder (
        .inst_i      (imem_data_i),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rd_addr_o   (rd_addr),
        .imm_o       (imm),
        .alu_op_o    (alu_op),
        .op1_sel_o   (op1_sel),
        .op2_sel_o   (op2_sel),
        .wb_sel_o    (wb_sel),
        .rf_wen_o    (rf_wen),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .is_branch_o (is_branch),
        .is_jump_o   (is_jump),
        .is_jalr_o   (is_jalr)
    );

    rv_execute u_execute (
        .pc_i         (pc),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .imm_i        (imm),
        .alu_op_i     (alu_op),
        .op1_sel_i    (op1_sel),
        .op2_sel_i    (op2_sel),
        .is_branch_i  (is_branch),
        .is_jump_i    (is_jump),
        .is_jalr_i    (is_jalr),
        .alu_result_o (alu_result),
        .link_o       (link),
        .next_pc_o    (next_pc)
    );

    rv_regfile u_regfile (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rd_addr_i    (rd_addr),
        .commit_i     (commit),
        .rf_wen_i     (rf_wen),
        .wb_sel_i     (wb_sel),
        .alu_result_i (alu_result),
        .link_i       (link),
        .load_data_i  (dmem_rdata_i),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data)
    );

    rv_control #(
        .RESET_PC (RESET_PC),
        .HALT_PC  (HALT_PC)
    ) u_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .is_load_i     (is_load),
        .is_store_i    (is_store),
        .next_pc_i     (next_pc),
        .dmem_ready_i  (dmem_ready_i),
        .dmem_rvalid_i (dmem_rvalid_i),
        .pc_o          (pc),
        .dmem_valid_o  (dmem_valid_o),
        .commit_o      (commit),
        .halt_o        (halt_o)
    );

endmodule

/* tb/rv_core_asserts.sv */
`timescale 1ns/1ps

module rv_core_asserts (
    input logic          clk,
    input logic          rst_n,
    input logic          dmem_valid_i,
    input logic          dmem_ready_i,
    input logic          dmem_we_i,
    input rv_pkg::word_t dmem_addr_i,
    input rv_pkg::word_t dmem_wdata_i,
    input logic          halt_i
);

    int fail_cnt = 0;

    // request held until accepted
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_valid_i && !dmem_ready_i |=> dmem_valid_i && $stable(dmem_we_i) &&
        $stable(dmem_addr_i) && $stable(dmem_wdata_i))
    else begin
        $error("data request changed while ready was low");
        fail_cnt++;
    end

    addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_valid_i |-> dmem_addr_i[1:0] == 2'b00)
    else begin
        $error("misaligned data address %h", dmem_addr_i);
        fail_cnt++;
    end

    quiet_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
        halt_i |-> !dmem_valid_i)
    else begin
        $error("data request while halted");
        fail_cnt++;
    end

endmodule

bind rv_core rv_core_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .dmem_valid_i (dmem_valid_o),
    .dmem_ready_i (dmem_ready_i),
    .dmem_we_i    (dmem_we_o),
    .dmem_addr_i  (dmem_addr_o),
    .dmem_wdata_i (dmem_wdata_o),
    .halt_i       (halt_o)
);

/* tb/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam rv_pkg::word_t RESET_PC = 32'h80;
    localparam rv_pkg::word_t HALT_PC  = 32'h800;
    localparam int            TIMEOUT  = 4000; // cycles per program

    logic          clk;
    logic          rst_n;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_data;
    logic          dmem_valid;
    logic          dmem_ready;
    logic          dmem_we;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    rv_pkg::word_t dmem_rdata;
    logic          dmem_rvalid;
    logic          halt;

    rv_pkg::word_t imem [1024];
    rv_pkg::word_t dmem [rv_pkg::word_t]; // sparse and keyed by byte address
    rv_pkg::word_t prog [$];
    rv_pkg::word_t exp_addr [$];
    rv_pkg::word_t exp_data [$];
    rv_pkg::word_t log_addr [$];
    rv_pkg::word_t log_data [$];
    rv_pkg::word_t saved_addr [$];
    rv_pkg::word_t saved_data [$];

    bit            stall_en;
    bit            rd_pending;
    int unsigned   rd_delay;
    rv_pkg::word_t rd_word;
    rv_pkg::word_t slot_addr;
    int            err_cnt;
    int            check_cnt;
    int            test_cnt;

    // operands drawn once so the stalled rerun sees the same program
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t br_a;
    rv_pkg::word_t br_b;
    logic [11:0]   imm_r;
    logic [4:0]    shamt_r;
    logic [19:0]   upper_r;

    rv_core #(
        .RESET_PC (RESET_PC),
        .HALT_PC  (HALT_PC)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_addr_o   (imem_addr),
        .imem_data_i   (imem_data),
        .dmem_valid_o  (dmem_valid),
        .dmem_ready_i  (dmem_ready),
        .dmem_we_o     (dmem_we),
        .dmem_addr_o   (dmem_addr),
        .dmem_wdata_o  (dmem_wdata),
        .dmem_rdata_i  (dmem_rdata),
        .dmem_rvalid_i (dmem_rvalid),
        .halt_o        (halt)
    );

    assign imem_data = imem[imem_addr[11:2]];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic rv_pkg::word_t fill_word(input rv_pkg::word_t addr);
        return {addr[15:0], ~addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic rv_pkg::word_t mem_read(input rv_pkg::word_t addr);
        return dmem.exists(addr) ? dmem[addr] : fill_word(addr);
    endfunction

    // data memory model acting on the falling edge
    always @(negedge clk) begin : mem_model
        logic rdy;
        dmem_rvalid = 1'b0;
        if (rd_pending) begin
            if (rd_delay == 0) begin
                dmem_rvalid = 1'b1;
                dmem_rdata  = rd_word;
                rd_pending  = 1'b0;
            end else begin
                rd_delay--;
            end
        end
        rdy        = !stall_en || ($urandom_range(2) == 0);
        dmem_ready = rdy;
        if (dmem_valid && rdy) begin // accepted at the coming rising edge
            if (dmem_we) begin
                dmem[dmem_addr] = dmem_wdata;
                log_addr.push_back(dmem_addr);
                log_data.push_back(dmem_wdata);
            end else begin
                rd_pending = 1'b1;
                rd_word    = mem_read(dmem_addr);
                rd_delay   = stall_en ? $urandom_range(4) : 0;
            end
        end
    end

    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                            input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::word_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                            input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic rv_pkg::word_t enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::word_t enc_b(input int imm, input int rs2, input int rs1,
                                            input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
                rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::word_t enc_u(input logic [19:0] imm, input int rd,
                                            input logic [6:0] opc);
        return {imm, rd[4:0], opc};
    endfunction

    function automatic rv_pkg::word_t enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::OPC_JAL};
    endfunction

    function automatic void emit(input rv_pkg::word_t inst);
        prog.push_back(inst);
    endfunction

    function automatic rv_pkg::word_t here();
        return RESET_PC + 4 * prog.size();
    endfunction

    // sw to the next slot and record the expected word
    function automatic void store_check(input int rs, input rv_pkg::word_t value);
        emit(enc_s(slot_addr, rs, 0));
        exp_addr.push_back(slot_addr);
        exp_data.push_back(value);
        slot_addr += 4;
    endfunction

    function automatic void start_program(input rv_pkg::word_t a, input rv_pkg::word_t b,
                                          input rv_pkg::word_t base);
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        dmem.delete();
        dmem[32'h100] = a;
        dmem[32'h104] = b;
        slot_addr     = base;
        emit(enc_i(32'h100, 0, 3'b010, 1, rv_pkg::OPC_LOAD)); // lw x1
        emit(enc_i(32'h104, 0, 3'b010, 2, rv_pkg::OPC_LOAD)); // lw x2
    endfunction

    function automatic void alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                   input rv_pkg::word_t value);
        emit(enc_r(f7, 2, 1, f3, 3));
        store_check(3, value);
    endfunction

    function automatic void alu_ri(input logic [2:0] f3, input logic [11:0] imm,
                                   input rv_pkg::word_t value);
        emit(enc_i(imm, 1, f3, 3, rv_pkg::OPC_OP_IMM));
        store_check(3, value);
    endfunction

    function automatic void build_alu_program();
        rv_pkg::word_t simm;
        rv_pkg::word_t pc;
        int            sh;
        simm = {{20{imm_r[11]}}, imm_r};
        sh   = op_b[4:0];
        start_program(op_a, op_b, 32'h200);
        alu_rr(7'h00, 3'b000, op_a + op_b);
        alu_rr(7'h20, 3'b000, op_a - op_b);
        alu_rr(7'h00, 3'b001, op_a << sh);
        alu_rr(7'h00, 3'b010, {31'b0, $signed(op_a) < $signed(op_b)});
        alu_rr(7'h00, 3'b011, {31'b0, op_a < op_b});
        alu_rr(7'h00, 3'b100, op_a ^ op_b);
        alu_rr(7'h00, 3'b101, op_a >> sh);
        alu_rr(7'h20, 3'b101, $signed(op_a) >>> sh);
        alu_rr(7'h00, 3'b110, op_a | op_b);
        alu_rr(7'h00, 3'b111, op_a & op_b);
        alu_ri(3'b000, imm_r, op_a + simm);
        alu_ri(3'b010, imm_r, {31'b0, $signed(op_a) < $signed(simm)});
        alu_ri(3'b011, imm_r, {31'b0, op_a < simm});
        alu_ri(3'b100, imm_r, op_a ^ simm);
        alu_ri(3'b110, imm_r, op_a | simm);
        alu_ri(3'b111, imm_r, op_a & simm);
        alu_ri(3'b001, {7'h00, shamt_r}, op_a << shamt_r);
        alu_ri(3'b101, {7'h00, shamt_r}, op_a >> shamt_r);
        alu_ri(3'b101, {7'h20, shamt_r}, $signed(op_a) >>> shamt_r);
        emit(enc_u(upper_r, 3, rv_pkg::OPC_LUI));
        store_check(3, {upper_r, 12'b0});
        pc = here();
        emit(enc_u(upper_r, 3, rv_pkg::OPC_AUIPC));
        store_check(3, pc + {upper_r, 12'b0});
    endfunction

    function automatic bit branch_taken(input logic [2:0] f3, input rv_pkg::word_t x,
                                        input rv_pkg::word_t y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    function automatic void build_branch_program();
        logic [2:0]    f3s [6];
        rv_pkg::word_t x;
        rv_pkg::word_t y;
        int            rs1;
        int            rs2;
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        start_program(br_a, br_b, 32'h300);
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 3; p++) begin // (a,b) (b,a) (a,a)
                rs1 = (p == 1) ? 2 : 1;
                rs2 = (p == 0) ? 2 : 1;
                x   = (rs1 == 1) ? br_a : br_b;
                y   = (rs2 == 1) ? br_a : br_b;
                emit(enc_b(8, rs2, rs1, f3s[i]));
                if (branch_taken(f3s[i], x, y)) begin
                    emit(enc_s(slot_addr, 0, 0)); // must be jumped over
                    slot_addr += 4;
                end else begin
                    store_check(0, 32'h0);
                end
            end
        end
    endfunction

    function automatic void build_jump_program();
        rv_pkg::word_t pc;
        rv_pkg::word_t tgt;
        start_program(32'h0, 32'h0, 32'h404);
        pc = here();
        emit(enc_j(8, 6));                 // jal x6, +8
        emit(enc_s(32'h400, 0, 0));        // skipped
        store_check(6, pc + 4);
        tgt = here() + 12;
        emit(enc_i(tgt, 0, 3'b000, 7, rv_pkg::OPC_OP_IMM));
        pc = here();
        emit(enc_i(1, 7, 3'b000, 8, rv_pkg::OPC_JALR)); // odd target with bit 0 dropped
        emit(enc_s(32'h3fc, 0, 0));        // skipped
        store_check(8, pc + 4);
    endfunction

    task automatic reset_dut();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic compare_stores(input string name);
        check_cnt++;
        if (log_addr.size() != exp_addr.size()) begin
            $display("** Error at %0t: %s logged %0d stores, expected %0d", $time, name,
                     log_addr.size(), exp_addr.size());
            err_cnt++;
        end
        for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
            check_cnt++;
            if (log_addr[i] !== exp_addr[i] || log_data[i] !== exp_data[i]) begin
                $display("** Error at %0t: %s store %0d wrote %h to %h, expected %h to %h",
                         $time, name, i, log_data[i], log_addr[i], exp_data[i], exp_addr[i]);
                err_cnt++;
            end
        end
    endtask

    task automatic run_program(input string name, input bit stalls);
        int cycles;
        for (int i = 0; i < 1024; i++)
            imem[i] = enc_j(HALT_PC - 4 * i, 0);
        for (int i = 0; i < prog.size(); i++)
            imem[RESET_PC[11:2] + i] = prog[i]; // program placed at the reset address
        log_addr.delete();
        log_data.delete();
        stall_en = stalls;
        reset_dut();
        check_cnt++;
        if (imem_addr !== RESET_PC || dmem_valid !== 1'b0 || halt !== 1'b0) begin
            $display("** Error at %0t: %s after reset pc %h valid %b halt %b", $time, name,
                     imem_addr, dmem_valid, halt);
            err_cnt++;
        end
        cycles = 0;
        while (halt !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (halt !== 1'b1) begin
            $display("timeout: %s did not reach the halt address in %0d cycles", name, TIMEOUT);
            err_cnt++;
        end else begin
            for (int i = 0; i < 16; i++) begin // quiet window after halt
                @(negedge clk);
                check_cnt++;
                if (dmem_valid !== 1'b0) begin
                    $display("** Error at %0t: %s issued a data request after halt", $time,
                             name);
                    err_cnt++;
                end
            end
            compare_stores(name);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        $display("test %s finished, %0d errors", name, err_cnt - errs_before);
    endtask

    task automatic test_reset();
        int e0;
        e0 = err_cnt;
        start_program(op_a, op_b, 32'h200); // loads only, no stores
        run_program("reset", 1'b0);
        report_test("reset", e0);
    endtask

    task automatic test_alu();
        int e0;
        e0 = err_cnt;
        build_alu_program();
        run_program("alu", 1'b0);
        saved_addr = log_addr;
        saved_data = log_data;
        report_test("alu", e0);
    endtask

    task automatic test_branch();
        int e0;
        e0 = err_cnt;
        build_branch_program();
        run_program("branch", 1'b0);
        report_test("branch", e0);
    endtask

    task automatic test_jump();
        int e0;
        e0 = err_cnt;
        build_jump_program();
        run_program("jump", 1'b0);
        report_test("jump", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        e0 = err_cnt;
        build_alu_program();
        run_program("backpressure", 1'b1);
        check_cnt++;
        if (log_addr.size() != saved_addr.size()) begin
            $display("** Error at %0t: stalled run logged %0d stores, unstalled %0d", $time,
                     log_addr.size(), saved_addr.size());
            err_cnt++;
        end else begin
            for (int i = 0; i < saved_addr.size(); i++) begin
                if (log_addr[i] !== saved_addr[i] || log_data[i] !== saved_data[i]) begin
                    $display("** Error at %0t: stalled store %0d is %h at %h, unstalled %h",
                             $time, i, log_data[i], log_addr[i], saved_data[i]);
                    err_cnt++;
                end
            end
        end
        report_test("backpressure", e0);
    endtask

    initial begin
        void'($urandom(32'h17cb_34c9));
        rst_n       = 1'b0;
        dmem_ready  = 1'b0;
        dmem_rvalid = 1'b0;
        dmem_rdata  = '0;
        stall_en    = 1'b0;
        rd_pending  = 1'b0;
        rd_delay    = 0;
        err_cnt     = 0;
        check_cnt   = 0;
        test_cnt    = 0;
        for (int i = 0; i < 1024; i++)
            imem[i] = enc_j(HALT_PC - 4 * i, 0);
        op_a    = $urandom;
        op_b    = $urandom;
        br_a    = $urandom;
        br_b    = br_a ^ ($urandom | 32'h1); // never equal to br_a
        imm_r   = $urandom;
        shamt_r = $urandom;
        upper_r = $urandom;

        test_reset();
        test_alu();
        test_branch();
        test_jump();
        test_backpressure();

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", test_cnt,
                 check_cnt, err_cnt, u_dut.u_asserts.fail_cnt);
        if (err_cnt == 0 && u_dut.u_asserts.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* project.f */
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_execute.sv
hw/rv_regfile.sv
hw/rv_control.sv
hw/rv_core.sv
tb/rv_core_asserts.sv
tb/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - hw/rv_pkg.sv
  - hw/rv_decoder.sv
  - hw/rv_execute.sv
  - hw/rv_regfile.sv
  - hw/rv_control.sv
  - hw/rv_core.sv
  - target: test
    files:
      - tb/rv_core_asserts.sv
      - tb/rv_core_tb.sv
